//--- sim.f
src/bramArrayPkg.sv
src/bramPortSteer.sv
src/bramCell.sv
src/bramArrayTop.sv
verif/bramArrayTb.sv

//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f sim.f --top-module bramArrayTb -o bramArrayTb
	@out="$$(./obj_dir/bramArrayTb)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "All checks passed"

clean:
	rm -rf obj_dir

//--- verif/bramArrayTb.sv
// Testbench for the block-RAM array: clock, reset, stimulus, shadow memory and read checks

`timescale 1ns/100ps

module bramArrayTb;

  localparam int NumParBrams = 3;
  localparam int NumSerBrams = 8;
  localparam int DataBits    = NumParBrams * 32;
  localparam int ByteEnBits  = NumParBrams * 4;
  localparam int RowWords    = 1024;
  localparam int TotalWords  = NumSerBrams * RowWords;
  localparam int PoolSize    = 2 * NumSerBrams;  // Two words per row for the random mix
  localparam int WaitLimit   = 20;               // Cycles any wait loop may take

  logic                  A_PS = 1'b0;
  logic                  arstN;

  logic                  aEn;
  bramArrayPkg::addrT    aAddr;
  logic [ByteEnBits-1:0] aWrEn;
  logic [DataBits-1:0]   aWrData;
  logic [DataBits-1:0]   aRdData;

  logic                  bEn;
  bramArrayPkg::addrT    bAddr;
  logic [ByteEnBits-1:0] bWrEn;
  logic [DataBits-1:0]   bWrData;
  logic [DataBits-1:0]   bRdData;

  integer seed = 32'h9cbf_efb0;
  int     errA;
  int     errB;
  int     timeouts;

  logic [DataBits-1:0] shadow [TotalWords];  // Indexed by word address
  logic [DataBits-1:0] expA;                 // Expected RdData, one cycle in flight
  logic [DataBits-1:0] expB;
  logic [DataBits-1:0] aNew;
  logic [DataBits-1:0] bNew;
  int                  aIdx;
  int                  bIdx;
  int                  pool [PoolSize];

  always #50 A_PS = ~A_PS;

  bramArrayTop bramArrayTop_i (
    .A_PS    (A_PS),
    .arstN   (arstN),
    .aEn     (aEn),
    .aAddr   (aAddr),
    .aWrEn   (aWrEn),
    .aWrData (aWrData),
    .aRdData (aRdData),
    .bEn     (bEn),
    .bAddr   (bAddr),
    .bWrEn   (bWrEn),
    .bWrData (bWrData),
    .bRdData (bRdData)
  );

  // Byte lane k takes new data when its enable is set
  function automatic logic [DataBits-1:0] applyBytes(
    input logic [DataBits-1:0]   oldWord,
    input logic [DataBits-1:0]   newWord,
    input logic [ByteEnBits-1:0] byteEn
  );
    logic [DataBits-1:0] result;
    result = oldWord;
    for (int k = 0; k < ByteEnBits; k++) begin
      if (byteEn[k]) begin
        result[8*k +: 8] = newWord[8*k +: 8];
      end
    end
    return result;
  endfunction

  function automatic logic [31:0] nextRand();
    return $random(seed);
  endfunction

  function automatic logic [DataBits-1:0] randWord();
    return DataBits'({nextRand(), nextRand(), nextRand()});
  endfunction

  // Shadow memory, both ports read the word before this cycle's writes
  always @(posedge A_PS or negedge arstN) begin
    if (!arstN) begin
      expA <= '0;  // Output registers clear on reset
      expB <= '0;
    end else begin
      aIdx = int'(aAddr >> 2);
      bIdx = int'(bAddr >> 2);
      if (aEn) aNew = applyBytes(shadow[aIdx], aWrData, aWrEn);
      if (bEn) bNew = applyBytes(shadow[bIdx], bWrData, bWrEn);
      if (aEn) begin
        shadow[aIdx] = aNew;
        expA <= aNew;  // Write-first, new word is read back
      end
      if (bEn) begin
        shadow[bIdx] = bNew;
        expB <= bNew;
      end
    end
  end

  // Read data must match the shadow every cycle, idle cycles included
  aReadCheck: assert property (@(posedge A_PS) disable iff (!arstN) aRdData == expA)
    else begin
      errA++;
      $display("[ERROR] %0t: port A read %h, expected %h", $time, aRdData, expA);
    end

  bReadCheck: assert property (@(posedge A_PS) disable iff (!arstN) bRdData == expB)
    else begin
      errB++;
      $display("[ERROR] %0t: port B read %h, expected %h", $time, bRdData, expB);
    end

  task automatic step();
    @(posedge A_PS);
  endtask

  task automatic setA(input logic en, input int word, input int off,
                      input logic [ByteEnBits-1:0] we, input logic [DataBits-1:0] data);
    aEn     <= en;
    aAddr   <= bramArrayPkg::addrT'(word * 4 + off);
    aWrEn   <= we;
    aWrData <= data;
  endtask

  task automatic setB(input logic en, input int word, input int off,
                      input logic [ByteEnBits-1:0] we, input logic [DataBits-1:0] data);
    bEn     <= en;
    bAddr   <= bramArrayPkg::addrT'(word * 4 + off);
    bWrEn   <= we;
    bWrData <= data;
  endtask

  task automatic writeA(input int word, input logic [ByteEnBits-1:0] we);
    step();
    setA(1'b1, word, 0, we, randWord());
    setB(1'b0, 0, 0, '0, '0);
  endtask

  task automatic readB(input int word, input int off);
    step();
    setA(1'b0, 0, 0, '0, '0);
    setB(1'b1, word, off, '0, randWord());  // Write data is ignored on a read
  endtask

  // First and last word of every row, written on A and read back on B
  task automatic rowBoundaryTest();
    for (int r = 0; r < NumSerBrams; r++) begin
      writeA(r * RowWords, '1);
      readB(r * RowWords, 3);
      writeA(r * RowWords + RowWords - 1, '1);
      readB(r * RowWords + RowWords - 1, 1);
    end
  endtask

  task automatic partialWriteTest();
    writeA(3 * RowWords + 77, '1);
    writeA(3 * RowWords + 77, 12'h421);  // One byte in each cell column
    readB(3 * RowWords + 77, 0);
    writeA(5 * RowWords + 300, '1);
    writeA(5 * RowWords + 300, 12'h090);
    readB(5 * RowWords + 300, 2);
  endtask

  // Byte enables set while En is low must not write
  task automatic idleWriteTest();
    writeA(6 * RowWords + 12, '1);
    step();
    setA(1'b0, 6 * RowWords + 12, 0, '1, randWord());
    setB(1'b0, 6 * RowWords + 12, 0, '1, randWord());
    step();
    step();
    readB(6 * RowWords + 12, 0);
  endtask

  task automatic randomMix(input int cycles);
    int ia;
    int ib;
    for (int r = 0; r < NumSerBrams; r++) begin
      pool[2*r]     = r * RowWords + int'(nextRand() % 512);
      pool[2*r + 1] = r * RowWords + 512 + int'(nextRand() % 512);
      writeA(pool[2*r], '1);
      writeA(pool[2*r + 1], '1);
    end
    for (int n = 0; n < cycles; n++) begin
      ia = int'(nextRand() % PoolSize);
      ib = (ia + 1 + int'(nextRand() % (PoolSize - 1))) % PoolSize;  // Never the same word
      step();
      setA((nextRand() % 4) != 0, pool[ia], int'(nextRand() % 4),
           nextRand() % 2 ? ByteEnBits'(nextRand()) : '0, randWord());
      setB((nextRand() % 4) != 0, pool[ib], int'(nextRand() % 4),
           nextRand() % 2 ? ByteEnBits'(nextRand()) : '0, randWord());
    end
  endtask

  task automatic waitReset();
    int cycles;
    cycles = 0;
    while (!arstN && cycles < WaitLimit) begin
      step();
      cycles++;
    end
    if (!arstN) begin
      $display("Timeout: reset was still asserted after %0d cycles", WaitLimit);
      timeouts++;
    end
  endtask

  // Idle both ports until two quiet edges have let the last read be checked
  task automatic drain();
    int cycles;
    int quiet;
    cycles = 0;
    quiet  = 0;
    step();
    setA(1'b0, 0, 0, '0, '0);
    setB(1'b0, 0, 0, '0, '0);
    while (quiet < 2 && cycles < WaitLimit) begin
      step();
      quiet = (aEn || bEn) ? 0 : quiet + 1;
      cycles++;
    end
    if (quiet < 2) begin
      $display("Timeout: ports did not go idle within %0d cycles", WaitLimit);
      timeouts++;
    end
  endtask

  task automatic endRun();
    $display("Errors: port A %0d, port B %0d, timeouts %0d", errA, errB, timeouts);
    if (errA + errB + timeouts == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  endtask

  initial begin
    errA     = 0;
    errB     = 0;
    timeouts = 0;
    arstN    = 1'b0;
    aEn      = 1'b0;
    aAddr    = '0;
    aWrEn    = '0;
    aWrData  = '0;
    bEn      = 1'b0;
    bAddr    = '0;
    bWrEn    = '0;
    bWrData  = '0;
    repeat (2) @(posedge A_PS);
    arstN <= 1'b1;
    waitReset();
    if (timeouts == 0) begin
      repeat (3) step();  // Zero outputs checked before any request
      rowBoundaryTest();
      partialWriteTest();
      idleWriteTest();
      randomMix(400);
      drain();
    end
    endRun();
  end

endmodule

//--- src/bramArrayTop.sv
// Grid of dual-port cells with one address steerer per port

`timescale 1ns/100ps

module bramArrayTop #(
  parameter int NumParBrams = 3,  // Cells side by side widen the word
  parameter int NumSerBrams = 8   // Rows deepen the address space
) (
  input  logic                                          A_PS,
  input  logic                                          arstN,

  // Port A
  input  logic                                          aEn,
  input  bramArrayPkg::addrT                            aAddr,
  input  logic [NumParBrams*bramArrayPkg::CellBytes-1:0] aWrEn,
  input  logic [NumParBrams*bramArrayPkg::CellBits-1:0]  aWrData,
  output logic [NumParBrams*bramArrayPkg::CellBits-1:0]  aRdData,

  // Port B
  input  logic                                          bEn,
  input  bramArrayPkg::addrT                            bAddr,
  input  logic [NumParBrams*bramArrayPkg::CellBytes-1:0] bWrEn,
  input  logic [NumParBrams*bramArrayPkg::CellBits-1:0]  bWrData,
  output logic [NumParBrams*bramArrayPkg::CellBits-1:0]  bRdData
);

  localparam int CellBits   = bramArrayPkg::CellBits;
  localparam int CellBytes  = bramArrayPkg::CellBytes;
  localparam int DataBits   = NumParBrams * CellBits;
  localparam int ByteEnBits = NumParBrams * CellBytes;

  // Word index shared by every cell of a port
  bramArrayPkg::wordIdxT aWordIdx;
  bramArrayPkg::wordIdxT bWordIdx;

  // Per-row byte enables after steering
  logic [NumSerBrams-1:0][ByteEnBits-1:0] aRowWrEn;
  logic [NumSerBrams-1:0][ByteEnBits-1:0] bRowWrEn;

  // Row read buses gathered from the cell outputs
  logic [NumSerBrams-1:0][DataBits-1:0]   aRowRdData;
  logic [NumSerBrams-1:0][DataBits-1:0]   bRowRdData;

  bramPortSteer #(
    .NumParBrams (NumParBrams),
    .NumSerBrams (NumSerBrams)
  ) portASteer_i (
    .A_PS      (A_PS),
    .arstN     (arstN),
    .en        (aEn),
    .addr      (aAddr),
    .wrEn      (aWrEn),
    .rowRdData (aRowRdData),
    .wordIdx   (aWordIdx),
    .rowWrEn   (aRowWrEn),
    .rdData    (aRdData)
  );

  bramPortSteer #(
    .NumParBrams (NumParBrams),
    .NumSerBrams (NumSerBrams)
  ) portBSteer_i (
    .A_PS      (A_PS),
    .arstN     (arstN),
    .en        (bEn),
    .addr      (bAddr),
    .wrEn      (bWrEn),
    .rowRdData (bRowRdData),
    .wordIdx   (bWordIdx),
    .rowWrEn   (bRowWrEn),
    .rdData    (bRdData)
  );

  // Row s of the grid holds word addresses s*1024 up to s*1024+1023
  for (genvar s = 0; s < NumSerBrams; s++) begin : gRow
    for (genvar p = 0; p < NumParBrams; p++) begin : gCol
      bramCell bramCell_i (
        .A_PS     (A_PS),
        .arstN    (arstN),
        .aEn      (aEn),                                // Every row reads and the steerer picks one
        .aWordIdx (aWordIdx),
        .aWrEn    (aRowWrEn[s][p*CellBytes +: CellBytes]),
        .aWrData  (aWrData[p*CellBits +: CellBits]),
        .aRdData  (aRowRdData[s][p*CellBits +: CellBits]),
        .bEn      (bEn),
        .bWordIdx (bWordIdx),
        .bWrEn    (bRowWrEn[s][p*CellBytes +: CellBytes]),
        .bWrData  (bWrData[p*CellBits +: CellBits]),
        .bRdData  (bRowRdData[s][p*CellBits +: CellBits])
      );
    end
  end

endmodule

//--- src/bramCell.sv
// 1024x32 true dual-port RAM with byte writes and write-first output registers

`timescale 1ns/100ps

module bramCell (
  input  logic                     A_PS,
  input  logic                     arstN,

  // Port A
  input  logic                     aEn,
  input  bramArrayPkg::wordIdxT    aWordIdx,
  input  bramArrayPkg::cellByteEnT aWrEn,
  input  bramArrayPkg::cellWordT   aWrData,
  output bramArrayPkg::cellWordT   aRdData,

  // Port B
  input  logic                     bEn,
  input  bramArrayPkg::wordIdxT    bWordIdx,
  input  bramArrayPkg::cellByteEnT bWrEn,
  input  bramArrayPkg::cellWordT   bWrData,
  output bramArrayPkg::cellWordT   bRdData
);

  bramArrayPkg::cellWordT mem [bramArrayPkg::CellWords];

  bramArrayPkg::cellWordT aNextWord;  // Stored word with port A bytes applied
  bramArrayPkg::cellWordT bNextWord;
  bramArrayPkg::cellWordT aRdQ;
  bramArrayPkg::cellWordT bRdQ;
  logic                   aWrite;
  logic                   bWrite;

  // Replace the enabled byte lanes of a word
  function automatic bramArrayPkg::cellWordT mergeBytes(
    input bramArrayPkg::cellWordT   oldWord,
    input bramArrayPkg::cellWordT   newWord,
    input bramArrayPkg::cellByteEnT byteEn
  );
    bramArrayPkg::cellWordT merged;
    merged = oldWord;
    for (int i = 0; i < bramArrayPkg::CellBytes; i++) begin
      if (byteEn[i]) begin
        merged[8*i +: 8] = newWord[8*i +: 8];
      end
    end
    return merged;
  endfunction

  assign aWrite = aEn && (|aWrEn);
  assign bWrite = bEn && (|bWrEn);

  assign aNextWord = mergeBytes(mem[aWordIdx], aWrData, aWrEn);
  assign bNextWord = mergeBytes(mem[bWordIdx], bWrData, bWrEn);

  // Storage array keeps its contents through reset
  always_ff @(posedge A_PS) begin
    if (aWrite) begin
      mem[aWordIdx] <= aNextWord;
    end
    if (bWrite) begin
      mem[bWordIdx] <= bNextWord;  // Port B wins a same-word clash
    end
  end

  // Write-first output registers that hold while the port is idle
  always_ff @(posedge A_PS or negedge arstN) begin
    if (!arstN) begin
      aRdQ <= '0;
      bRdQ <= '0;
    end else begin
      if (aEn) begin
        aRdQ <= aNextWord;
      end
      if (bEn) begin
        bRdQ <= bNextWord;
      end
    end
  end

  assign aRdData = aRdQ;
  assign bRdData = bRdQ;

  // Double write to one word in the same cycle has no defined result
  noDoubleWrite: assert property (
    @(posedge A_PS) disable iff (!arstN)
    !(aWrite && bWrite && (aWordIdx == bWordIdx))
  ) else $error("Both ports write word %0d in the same cycle", aWordIdx);

endmodule

//--- src/bramPortSteer.sv
// Byte address split, per-row write-enable steering, row-index register and read mux

`timescale 1ns/100ps

module bramPortSteer #(
  parameter int NumParBrams = 3,
  parameter int NumSerBrams = 8
) (
  input  logic                    A_PS,
  input  logic                    arstN,

  // Port request as plain levels sampled on the rising edge
  input  logic                    en,
  input  bramArrayPkg::addrT      addr,
  input  logic [NumParBrams*bramArrayPkg::CellBytes-1:0] wrEn,

  // Read words of every row one cycle after the request
  input  logic [NumSerBrams-1:0][NumParBrams*bramArrayPkg::CellBits-1:0] rowRdData,

  // Towards the cell grid
  output bramArrayPkg::wordIdxT   wordIdx,
  output logic [NumSerBrams-1:0][NumParBrams*bramArrayPkg::CellBytes-1:0] rowWrEn,

  // Selected read word of the row addressed last enabled cycle
  output logic [NumParBrams*bramArrayPkg::CellBits-1:0] rdData
);

  localparam int DataBits    = NumParBrams * bramArrayPkg::CellBits;

  // Low address bits that pick a byte inside a cell word
  localparam int ByteOffBits = $clog2(bramArrayPkg::CellBytes);

  // Everything above the word index is the row index
  localparam int RowFullBits = $bits(bramArrayPkg::addrT) - ByteOffBits
                               - bramArrayPkg::WordIdxBits;

  // Stored row index width of at least one bit
  localparam int RowBits     = (NumSerBrams > 1) ? $clog2(NumSerBrams) : 1;

  logic [RowFullBits-1:0] rowIdx;   // Row addressed this cycle
  logic [RowBits-1:0]     rowIdxQ;  // Row addressed on the last enabled edge
  logic [DataBits-1:0]    selWord;

  // Address split is combinational in the request cycle
  assign wordIdx = addr[ByteOffBits +: bramArrayPkg::WordIdxBits];
  assign rowIdx  = addr[$bits(bramArrayPkg::addrT)-1 -: RowFullBits];

  // Byte enables reach only the addressed row
  always_comb begin
    for (int r = 0; r < NumSerBrams; r++) begin
      if (en && (rowIdx == RowFullBits'(r))) begin
        rowWrEn[r] = wrEn;
      end else begin
        rowWrEn[r] = '0;  // Other rows see no write
      end
    end
  end

  // Row index follows the cell output registers by one cycle
  always_ff @(posedge A_PS or negedge arstN) begin
    if (!arstN) begin
      rowIdxQ <= '0;
    end else if (en) begin
      rowIdxQ <= rowIdx[RowBits-1:0];
    end
  end

  // Read select
  always_comb begin
    selWord = rowRdData[0];
    for (int r = 1; r < NumSerBrams; r++) begin
      if (rowIdxQ == RowBits'(r)) begin
        selWord = rowRdData[r];
      end
    end
  end

  assign rdData = selWord;

  // Guard against addresses past the last row
  rowInRange: assert property (
    @(posedge A_PS) disable iff (!arstN)
    en |-> (rowIdx < RowFullBits'(NumSerBrams))
  ) else $error("Row index %0d out of range, %0d rows present", rowIdx, NumSerBrams);

endmodule

//--- src/bramArrayPkg.sv
// Cell geometry constants and the address, word-index, data and byte-enable vector types

package bramArrayPkg;

  // Geometry of one block-RAM cell
  localparam int CellBits    = 32;                // Data bits per cell word
  localparam int CellBytes   = CellBits / 8;      // Byte lanes per cell word
  localparam int CellWords   = 1024;              // Words per cell
  localparam int WordIdxBits = $clog2(CellWords); // Width of the word index, 10

  // Byte address as presented at either port of the array
  typedef logic [31:0] addrT;

  // Word index inside one cell
  typedef logic [WordIdxBits-1:0] wordIdxT;

  // One cell's data word and its byte enables
  typedef logic [CellBits-1:0]  cellWordT;
  typedef logic [CellBytes-1:0] cellByteEnT;

  // The array's data word is NumParBrams cell words side by side.
  // Byte lane k of that word lives in cell column k / CellBytes,
  // bit range [8*k +: 8] of the port word.
  //
  // A byte address splits as
  //   [1:0]                  byte within the cell word, ignored
  //   [WordIdxBits+1:2]      word index inside the cell
  //   [31:WordIdxBits+2]     row index, must stay below NumSerBrams
  //
  // Both ports run on one clock. Same-word collisions between the ports
  // give undefined data; the cells flag the double-write case.

endpackage
